// File: vmsu_pkg.sv
// Operand and product widths, mode encoding and pipeline stage structs
`default_nettype none

package vmsu_pkg;

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // Values of the control input
    localparam logic MODE_UNSIGNED = 1'b0;
    localparam logic MODE_SIGNED = 1'b1;

    // Raw operands as sampled by the input register
    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     is_signed;
    } operands_t;

    // Operand magnitudes plus the sign of each original operand
    typedef struct packed {
        operand_t mag_a;
        operand_t mag_b;
        logic     neg_a;
        logic     neg_b;
    } magnitudes_t;

    // Unsigned product and whether it must be negated
    typedef struct packed {
        product_t mag;
        logic     negate;
    } signed_product_t;

endpackage

`default_nettype wire

// File: vmsu_cla.sv
// Width-parameterized carry-lookahead adder
`timescale 1ns/1ns
`default_nettype none

module vmsu_cla #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] gen;
    logic [WIDTH:0]   carry;

    assign prop = a ^ b;
    assign gen  = a & b;

    // Each carry is built from generate/propagate terms and cin only
    always_comb begin
        logic c_next;
        logic run;
        carry[0] = cin;
        for (int i = 0; i < WIDTH; i++) begin
            c_next = gen[i];
            run    = prop[i];
            for (int j = i - 1; j >= 0; j--) begin
                c_next = c_next | (run & gen[j]);
                run    = run & prop[j];
            end
            carry[i+1] = c_next | (run & cin);
        end
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

`default_nettype wire

// File: vmsu_vedic_mult.sv
// Recursive Vedic unsigned multiplier with a 2-bit half-adder base case
`timescale 1ns/1ns
`default_nettype none

module vmsu_vedic_mult #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] p
);

    generate
        if (WIDTH == 2) begin : g_base
            logic [2:0] pp;
            logic       ha_carry;

            // Partial products a0b1, a1b0, a1b1
            assign pp[0] = a[0] & b[1];
            assign pp[1] = a[1] & b[0];
            assign pp[2] = a[1] & b[1];

            assign p[0]     = a[0] & b[0];
            assign p[1]     = pp[0] ^ pp[1];
            assign ha_carry = pp[0] & pp[1];
            assign p[2]     = pp[2] ^ ha_carry;
            assign p[3]     = pp[2] & ha_carry;
        end else begin : g_split
            localparam int HALF = WIDTH / 2;

            logic [WIDTH-1:0] prod_ll;
            logic [WIDTH-1:0] prod_lh;
            logic [WIDTH-1:0] prod_hl;
            logic [WIDTH-1:0] prod_hh;
            logic [WIDTH-1:0] mid_sum;
            logic [WIDTH-1:0] low_sum;
            logic             mid_carry;
            logic             low_carry;
            logic             top_in_carry;

            vmsu_vedic_mult #(.WIDTH(HALF)) i_mult_ll (
                .a(a[HALF-1:0]),
                .b(b[HALF-1:0]),
                .p(prod_ll)
            );
            vmsu_vedic_mult #(.WIDTH(HALF)) i_mult_lh (
                .a(a[HALF-1:0]),
                .b(b[WIDTH-1:HALF]),
                .p(prod_lh)
            );
            vmsu_vedic_mult #(.WIDTH(HALF)) i_mult_hl (
                .a(a[WIDTH-1:HALF]),
                .b(b[HALF-1:0]),
                .p(prod_hl)
            );
            vmsu_vedic_mult #(.WIDTH(HALF)) i_mult_hh (
                .a(a[WIDTH-1:HALF]),
                .b(b[WIDTH-1:HALF]),
                .p(prod_hh)
            );

            // Cross terms
            vmsu_cla #(.WIDTH(WIDTH)) i_cla_mid (
                .a(prod_lh),
                .b(prod_hl),
                .cin(1'b0),
                .sum(mid_sum),
                .cout(mid_carry)
            );

            // Fold in the upper half of the low product
            vmsu_cla #(.WIDTH(WIDTH)) i_cla_low (
                .a(mid_sum),
                .b({{HALF{1'b0}}, prod_ll[WIDTH-1:HALF]}),
                .cin(1'b0),
                .sum(low_sum),
                .cout(low_carry)
            );

            assign top_in_carry = mid_carry | low_carry;

            // Top half never overflows, so its carry out is left open
            vmsu_cla #(.WIDTH(WIDTH)) i_cla_top (
                .a(prod_hh),
                .b({{(HALF-1){1'b0}}, top_in_carry, low_sum[WIDTH-1:HALF]}),
                .cin(1'b0),
                .sum(p[2*WIDTH-1:WIDTH]),
                .cout()
            );

            assign p[HALF-1:0]     = prod_ll[HALF-1:0];
            assign p[WIDTH-1:HALF] = low_sum[HALF-1:0];
        end
    endgenerate

endmodule

`default_nettype wire

// File: vmsu_sign_stage.sv
// Signed-mode operand magnitude conversion and its pipeline register
`timescale 1ns/1ns
`default_nettype none

module vmsu_sign_stage import vmsu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  operands_t   ops,
    output magnitudes_t mags
);

    // Or-chain two's complement flips every bit above the lowest set one
    function automatic operand_t twos_comp(operand_t v);
        operand_t r;
        logic     seen;
        seen = 1'b0;
        for (int i = 0; i < OPERAND_W; i++) begin
            r[i] = v[i] ^ seen;
            seen = seen | v[i];
        end
        return r;
    endfunction

    logic neg_a;
    logic neg_b;

    assign neg_a = (ops.is_signed == MODE_SIGNED) && ops.a[OPERAND_W-1];
    assign neg_b = (ops.is_signed == MODE_SIGNED) && ops.b[OPERAND_W-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mags <= '0;
        end else begin
            mags.mag_a <= neg_a ? twos_comp(ops.a) : ops.a;
            mags.mag_b <= neg_b ? twos_comp(ops.b) : ops.b;
            mags.neg_a <= neg_a;
            mags.neg_b <= neg_b;
        end
    end

    // Unsigned operands pass through unchanged and never flagged negative
    a_no_neg_unsigned: assert property (
        @(posedge clk) disable iff (rst)
        ops.is_signed == MODE_UNSIGNED |=> !mags.neg_a && !mags.neg_b
            && mags.mag_a == $past(ops.a) && mags.mag_b == $past(ops.b)
    );

    // In signed mode a flagged magnitude negates back to the sampled operand
    a_mag_negates_back: assert property (
        @(posedge clk) disable iff (rst)
        ops.is_signed == MODE_SIGNED |=>
            (!mags.neg_a || operand_t'(mags.mag_a + $past(ops.a)) == '0) &&
            (!mags.neg_b || operand_t'(mags.mag_b + $past(ops.b)) == '0)
    );

endmodule

`default_nettype wire

// File: vmsu_product_stage.sv
// Magnitude multiply and the product pipeline register
`timescale 1ns/1ns
`default_nettype none

module vmsu_product_stage import vmsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  magnitudes_t     mags,
    output signed_product_t prod
);

    product_t mult_p;

    vmsu_vedic_mult #(.WIDTH(OPERAND_W)) i_vedic_mult (
        .a(mags.mag_a),
        .b(mags.mag_b),
        .p(mult_p)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod <= '0;
        end else begin
            prod.mag    <= mult_p;
            // Result is negative when exactly one operand was
            prod.negate <= mags.neg_a ^ mags.neg_b;
        end
    end

endmodule

`default_nettype wire

// File: vmsu_sign_restore.sv
// Conditional product negation and the output register
`timescale 1ns/1ns
`default_nettype none

module vmsu_sign_restore import vmsu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  signed_product_t prod,
    output product_t        p
);

    // Or-chain two's complement over the full product width
    function automatic product_t twos_comp(product_t v);
        product_t r;
        logic     seen;
        seen = 1'b0;
        for (int i = 0; i < PRODUCT_W; i++) begin
            r[i] = v[i] ^ seen;
            seen = seen | v[i];
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p <= '0;
        end else begin
            p <= prod.negate ? twos_comp(prod.mag) : prod.mag;
        end
    end

    // Whole pipeline must deliver clean products out of reset
    a_p_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(p)
    );

endmodule

`default_nettype wire

// File: vmsu_top.sv
// Multiplier top level with input register and the three pipeline stages
`timescale 1ns/1ns
`default_nettype none

module vmsu_top import vmsu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  operand_t a,
    input  operand_t b,
    input  logic     control,
    output product_t p
);

    operands_t       ops_q;
    magnitudes_t     mags;
    signed_product_t prod;

    // Operands sampled every clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ops_q <= '0;
        end else begin
            ops_q.a         <= a;
            ops_q.b         <= b;
            ops_q.is_signed <= control;
        end
    end

    vmsu_sign_stage i_sign_stage (
        .clk(clk),
        .rst(rst),
        .ops(ops_q),
        .mags(mags)
    );

    vmsu_product_stage i_product_stage (
        .clk(clk),
        .rst(rst),
        .mags(mags),
        .prod(prod)
    );

    vmsu_sign_restore i_sign_restore (
        .clk(clk),
        .rst(rst),
        .prod(prod),
        .p(p)
    );

endmodule

`default_nettype wire

// File: tb_vmsu.sv
// Testbench for the pipelined Vedic multiplier: file vectors, LCG vectors, product checks
`timescale 1ns/1ns
`default_nettype none

module tb_vmsu import vmsu_pkg::*; ();

    localparam int RESET_CYCLES  = 16;
    localparam int LATENCY       = 4;
    localparam int RAND_VECS     = 64;
    localparam int MAX_FILE_VECS = 64;

    typedef struct packed {
        logic     mode;
        operand_t a;
        operand_t b;
        product_t p;
    } vector_t;

    // Expectation waiting for its product to reach p
    typedef struct packed {
        int       idx;
        int       due;
        product_t exp;
    } pending_t;

    logic     clk;
    logic     rst;
    operand_t a;
    operand_t b;
    logic     control;
    product_t p;

    logic [35:0] file_mem [0:MAX_FILE_VECS-1];
    vector_t     vecs [$];
    pending_t    pend_q [$];

    int cycle = 0;
    int timeout_limit = 0;
    bit limit_set = 1'b0;
    int pass_count = 0;
    int fail_count = 0;

    vmsu_top i_vmsu_top (
        .clk(clk),
        .rst(rst),
        .a(a),
        .b(b),
        .control(control),
        .p(p)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit_set && cycle >= timeout_limit) begin
            $display("Run timed out after %0d cycles before all products were checked", cycle);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reference rule: plain product, or signed product modulo 2^PRODUCT_W
    function automatic product_t expected_product(logic mode, operand_t x, operand_t y);
        int sx;
        int sy;
        if (mode == MODE_SIGNED) begin
            sx = int'($signed(x));
            sy = int'($signed(y));
        end else begin
            sx = int'(x);
            sy = int'(y);
        end
        return product_t'(sx * sy);
    endfunction

    task automatic check_product(input int idx, input string name, input product_t got,
                                 input product_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("FAIL vec %0d %s: got 0x%h expected 0x%h", idx, name, got, exp);
        end
    endtask

    task automatic check_logic(input string name, input logic got, input logic exp,
                               output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("FAIL %s: got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic load_file_vectors();
        vector_t v;
        int      i;
        // Mode nibble f marks a slot the file did not fill
        for (i = 0; i < MAX_FILE_VECS; i++) begin
            file_mem[i] = {4'hf, 32'(i)};
        end
        $readmemh("vmsu_tests.txt", file_mem);
        i = 0;
        while (i < MAX_FILE_VECS && file_mem[i][35:32] <= 4'h1) begin
            v.mode = file_mem[i][32];
            v.a    = file_mem[i][31:24];
            v.b    = file_mem[i][23:16];
            v.p    = file_mem[i][15:0];
            vecs.push_back(v);
            i++;
        end
    endtask

    task automatic add_random_vectors();
        vector_t     v;
        logic [31:0] state;
        state = 32'h552d;
        for (int i = 0; i < RAND_VECS; i++) begin
            state  = lcg_next(state);
            v.mode = state[31];
            v.a    = state[23:16];
            v.b    = state[15:8];
            v.p    = expected_product(v.mode, v.a, v.b);
            vecs.push_back(v);
        end
    endtask

    initial begin
        vector_t  v;
        pending_t pe;
        bit       ok;
        bit       zero_ok;
        int       file_count;
        int       next_vec;
        int       done_count;

        rst     = 1'b1;
        a       = '0;
        b       = '0;
        control = MODE_UNSIGNED;
        zero_ok = 1'b1;

        load_file_vectors();
        file_count = vecs.size();
        add_random_vectors();
        timeout_limit = vecs.size() + RESET_CYCLES + LATENCY + 20;
        limit_set     = 1'b1;

        if (file_count == 0) begin
            $display("Test vector file vmsu_tests.txt held no vectors");
            fail_count++;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_logic("p_zero_in_reset", p == '0, 1'b1, ok);
            zero_ok = zero_ok & ok;
        end
        rst = 1'b0;

        next_vec   = 0;
        done_count = 0;
        while (done_count < vecs.size()) begin
            if (pend_q.size() > 0 && pend_q[0].due == cycle) begin
                if (done_count == 0) begin
                    if (zero_ok) begin
                        $display("ok   reset: p held at zero until the first product");
                        pass_count++;
                    end else begin
                        fail_count++;
                    end
                end
                pe = pend_q.pop_front();
                v  = vecs[pe.idx];
                check_product(pe.idx, "p", p, pe.exp, ok);
                if (ok) begin
                    $display("ok   vec %0d: mode %0d a 0x%h b 0x%h p 0x%h",
                             pe.idx, v.mode, v.a, v.b, p);
                    pass_count++;
                end else begin
                    fail_count++;
                end
                done_count++;
            end else if (done_count == 0) begin
                check_logic("p_zero_before_first_product", p == '0, 1'b1, ok);
                zero_ok = zero_ok & ok;
            end else begin
                $display("Product for vec %0d missing at its due cycle", pend_q[0].idx);
                fail_count++;
                void'(pend_q.pop_front());
                done_count++;
            end

            if (next_vec < vecs.size()) begin
                v       = vecs[next_vec];
                a       = v.a;
                b       = v.b;
                control = v.mode;
                pe.idx  = next_vec;
                pe.due  = cycle + LATENCY;
                pe.exp  = v.p;
                pend_q.push_back(pe);
                next_vec++;
            end
            @(negedge clk);
        end

        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vmsu_tests.txt
// Columns: mode (0 unsigned, 1 signed) _ a _ b _ expected product, all hex
// One vector per line, applied one per clock in file order
// Unsigned mode
0_00_00_0000
0_00_ff_0000
0_01_01_0001
0_01_ff_00ff
0_ff_01_00ff
0_ff_ff_fe01
0_80_80_4000
0_02_40_0080
0_10_10_0100
0_0d_0b_008f
0_80_ff_7f80
// Signed mode, all sign combinations
1_80_80_4000
1_80_7f_c080
1_7f_80_c080
1_ff_ff_0001
1_7f_7f_3f01
1_05_fd_fff1
1_fd_05_fff1
1_fd_fd_0009
1_ff_01_ffff
1_00_80_0000
1_80_01_ff80
// Mode alternating every cycle
0_ff_ff_fe01
1_ff_ff_0001
0_80_80_4000
1_80_7f_c080
0_80_7f_3f80
1_81_02_ff02
0_81_02_0102
1_c0_c0_1000

// File: build.f
vmsu_pkg.sv
vmsu_cla.sv
vmsu_vedic_mult.sv
vmsu_sign_stage.sv
vmsu_product_stage.sv
vmsu_sign_restore.sv
vmsu_top.sv
tb_vmsu.sv

// File: Makefile
# Verilator build and run for the Vedic multiplier testbench

VERILATOR  ?= verilator
TOP        ?= tb_vmsu
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
SIM        ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
